/* Makefile */
# Verilator simulation of the console support logic

TOP = tb_gb_support
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass or fail from $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing -f project.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* project.f */
verilog/gb_support_pkg.sv
verilog/download_router.sv
verilog/boot_rom_monitor.sv
verilog/cheat_code_loader.sv
verilog/backup_sector_sequencer.sv
verilog/gb_support_top.sv
verif/tb_sd_host_model.sv
verif/tb_gb_support.sv

/* verif/tb_gb_support.sv */
// Testbench for the console support logic
// Covers download classes, boot ROM checksum, cheat codes and backup RAM transfers

module tb_gb_support;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period    = 40;
	localparam int sector_words  = 8;
	// Boot ROM words over the three checksum runs
	localparam int boot_words    = 64 + 361 + 380;
	// Sectors in the auto load, user load, save and autosave
	localparam int sector_total  = 5 + 3 + 3 + 3;
	// Request, acknowledge, two cycles per word, then the falling acknowledge
	localparam int sector_cycles = 2 * sector_words + 4;
	// Reset, classes, cheat code and the gaps between tests
	localparam int misc_cycles   = 100;
	localparam int total_cycles  = boot_words + sector_total * sector_cycles + misc_cycles;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        ioctl_download, ioctl_wr, is_gbc;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic [7:0]  filetype;
	logic        img_mounted, img_readonly, img_size_nonzero, cart_has_save;
	logic        sd_ack, sd_buff_wr;
	logic [7:0]  sd_buff_addr, ram_mask_file;
	logic [15:0] sd_buff_dout, bk_q;
	logic        rtc_inuse, cram_wr, osd_status, load_req, save_req, autosave_en;
	logic [31:0] rtc_timestamp;
	logic [47:0] rtc_savedtime;
	logic        cart_download, palette_download, border_download, boot_download;
	logic        fastboot_available, boot_gba_available, real_cgb_boot, code_valid;
	gb_support_pkg::cheat_code_t cheat_code;
	logic [31:0] sd_lba;
	logic        sd_rd, sd_wr, bk_wr, bk_rtc_wr, bk_busy, bk_loading;
	logic        sav_pending, sav_supported;
	logic [15:0] sd_buff_din, bk_data;
	logic [15:0] bk_addr;

	// Monitor state
	logic        prev_req = 1'b0;
	logic        loading_exp = 1'b0;
	int          exp_lba, sectors, wr_count, rtc_count, valid_count;
	logic [15:0] cheat_words[8];

	always #(clk_period / 2) clk_sys = ~clk_sys;

	// Backup RAM returns a word derived from its address
	assign bk_q = bk_addr ^ 16'h5A5A;

	gb_support_top #(.LBA_W(32)) DUT (.*);

	tb_sd_host_model #(.WORDS(sector_words)) u_sd_host (
		.clk_sys(clk_sys), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba[7:0]),
		.sd_ack(sd_ack), .sd_buff_addr(sd_buff_addr), .sd_buff_wr(sd_buff_wr),
		.sd_buff_dout(sd_buff_dout)
	);

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("FAILED %s expected %h actual %h", name, exp, act);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	////////////////////
	// Reference model
	////////////////////
	// {cart, palette, border, boot}
	function automatic logic [3:0] expected_class(input logic [7:0] ft);
		logic cart;
		cart = (ft[5:0] == gb_support_pkg::ft_cart_low) || (ft == gb_support_pkg::ft_cart_alt);
		return {cart, ft == gb_support_pkg::ft_palette, ft == gb_support_pkg::ft_sgb_border,
			ft == gb_support_pkg::ft_cgb_boot || ft == gb_support_pkg::ft_dmg_boot ||
			ft == gb_support_pkg::ft_sgb_boot};
	endfunction

	function automatic logic [17:0] byte_checksum(input logic [15:0] words[$]);
		logic [17:0] sum;
		sum = '0;
		foreach (words[i])
			sum = sum + words[i][15:8] + words[i][7:0];
		return sum;
	endfunction

	// {fastboot, gba, real} with both custom ROMs loaded on a colour console
	function automatic logic [2:0] boot_flags_for(input logic [17:0] sum);
		logic custom, orig;
		custom = (sum == gb_support_pkg::cgb_custom_checksum);
		orig   = (sum == gb_support_pkg::cgb_original_checksum);
		return {custom, custom | orig, orig};
	endfunction

	// Field k is built from offsets 4k (low) and 4k+2 (high)
	function automatic logic [31:0] cheat_field(input int k);
		return {cheat_words[2*k+1], cheat_words[2*k]};
	endfunction

	function automatic int sector_count(input logic [7:0] mask, input logic rtc);
		return int'(mask) + 1 + int'(rtc);
	endfunction

	function automatic logic [15:0] save_word(input logic [7:0] lba, input logic [7:0] addr);
		logic [79:0] clock_bits;
		clock_bits = {rtc_savedtime, rtc_timestamp};
		if (lba <= ram_mask_file)
			return {lba, addr} ^ 16'h5A5A;
		else if (addr < gb_support_pkg::rtc_words)
			return clock_bits[addr*16 +: 16];
		else
			return 16'hFFFF;
	endfunction

	// Compare process, sampled mid-cycle
	always @(negedge clk_sys) begin
		if ((sd_rd || sd_wr) && !prev_req) begin
			check_value("sector order", exp_lba, sd_lba);
			check_value("transfer direction", {loading_exp, ~loading_exp}, {sd_rd, sd_wr});
			check_value("bk_loading", loading_exp, bk_loading);
			exp_lba = exp_lba + 1;
			sectors = sectors + 1;
		end
		prev_req = sd_rd || sd_wr;
		if (bk_wr) begin
			check_value("bk_wr in range", 1, sd_lba[7:0] <= ram_mask_file);
			check_value("bk_addr", {exp_lba[7:0] - 8'd1, sd_buff_addr}, bk_addr);
			check_value("bk_data", sd_buff_dout, bk_data);
			wr_count = wr_count + 1;
		end
		if (bk_rtc_wr) begin
			check_value("rtc sector", ram_mask_file + 1, sd_lba);
			rtc_count = rtc_count + 1;
		end
		if (sd_ack && !loading_exp)
			check_value("save data", save_word(exp_lba[7:0] - 8'd1, sd_buff_addr), sd_buff_din);
		if (code_valid)
			valid_count = valid_count + 1;
	end

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic host_write(input logic [24:0] addr, input logic [15:0] data);
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		next_cycle();
		ioctl_wr = 1'b0;
	endtask

	task automatic boot_download_run(input string name, input logic [15:0] words[$]);
		logic [2:0] exp;
		filetype       = gb_support_pkg::ft_cgb_boot;
		ioctl_download = 1'b1;
		repeat (3) next_cycle();
		foreach (words[i])
			host_write(25'(2 * i), words[i]);
		ioctl_download = 1'b0;
		next_cycle();
		exp = boot_flags_for(byte_checksum(words));
		check_value(name, exp, {fastboot_available, boot_gba_available, real_cgb_boot});
	endtask

	task automatic start_counts(input logic load);
		loading_exp = load;
		exp_lba     = 0;
		sectors     = 0;
		wr_count    = 0;
		rtc_count   = 0;
	endtask

	task automatic wait_transfer();
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
		next_cycle();
	endtask

	task automatic check_load(input string name);
		check_value({name, " sectors"}, sector_count(ram_mask_file, rtc_inuse), sectors);
		check_value({name, " bk_wr"}, (ram_mask_file + 1) * sector_words, wr_count);
		check_value({name, " bk_rtc_wr"}, rtc_inuse ? sector_words : 0, rtc_count);
	endtask

	// Watchdog
	initial begin
		#(2 * total_cycles * clk_period);
		$display("Simulation timed out before the tests completed");
		$display("Verification failed");
		$fatal(1);
	end

	initial begin
		logic [7:0]  types[$];
		logic [15:0] words[$];
		int          unused_seed;
		unused_seed = $urandom(76655);
		reset = 1'b1;
		{ioctl_download, ioctl_wr, ioctl_addr, ioctl_dout, filetype} = '0;
		{img_mounted, img_readonly, img_size_nonzero, cart_has_save} = '0;
		{rtc_inuse, cram_wr, osd_status, load_req, save_req, autosave_en} = '0;
		{rtc_timestamp, rtc_savedtime, ram_mask_file} = '0;
		is_gbc = 1'b1;
		start_counts(1'b0);
		valid_count = 0;
		repeat (5) next_cycle();
		reset = 1'b0;
		next_cycle();

		// Download classes
		types = '{8'h01, 8'h41, 8'h80, 8'h81, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'hFF, 8'h10};
		foreach (types[i]) begin
			filetype       = types[i];
			ioctl_download = 1'b1;
			next_cycle();
			check_value("download class", expected_class(types[i]),
				{cart_download, palette_download, border_download, boot_download});
			ioctl_download = 1'b0;
			next_cycle();
			check_value("class idle", 0,
				{cart_download, palette_download, border_download, boot_download});
		end

		// Colour boot ROM checksum
		words = {};
		repeat (64)
			words.push_back($urandom);
		boot_download_run("random boot rom", words);
		words = {};
		repeat (360)
			words.push_back(16'hFFFF);
		words.push_back(16'h00E0);
		boot_download_run("custom boot rom", words);
		words.insert(0, 16'hFFFF);
		repeat (18)
			words.insert(0, 16'hFFFF);
		boot_download_run("original boot rom", words);

		// Cheat code
		filetype       = gb_support_pkg::ft_cheat;
		ioctl_download = 1'b1;
		next_cycle();
		for (int i = 0; i < 8; i++) begin
			cheat_words[i] = $urandom;
			host_write(25'(2 * i), cheat_words[i]);
		end
		ioctl_download = 1'b0;
		repeat (2) next_cycle();
		check_value("code_valid pulses", 1, valid_count);
		check_value("cheat flags", cheat_field(0), cheat_code.fields.flags);
		check_value("cheat address", cheat_field(1), cheat_code.fields.address);
		check_value("cheat compare", cheat_field(2), cheat_code.fields.compare);
		check_value("cheat replace", cheat_field(3), cheat_code.fields.replace);

		// Load after a cartridge download, clock sector included
		{img_mounted, img_size_nonzero, cart_has_save, rtc_inuse} = 4'b1111;
		ram_mask_file  = 8'd3;
		start_counts(1'b1);
		filetype       = gb_support_pkg::ft_cart_alt;
		ioctl_download = 1'b1;
		repeat (3) next_cycle();
		ioctl_download = 1'b0;
		wait_transfer();
		check_load("auto load");
		check_value("sav_supported", 1, sav_supported);

		// User load without the clock
		rtc_inuse     = 1'b0;
		ram_mask_file = 8'd2;
		start_counts(1'b1);
		load_req = 1'b1;
		next_cycle();
		load_req = 1'b0;
		wait_transfer();
		check_load("user load");

		// Save with the clock sector
		rtc_inuse     = 1'b1;
		ram_mask_file = 8'd1;
		rtc_timestamp = $urandom;
		rtc_savedtime = {16'($urandom), 32'($urandom)};
		start_counts(1'b0);
		save_req = 1'b1;
		next_cycle();
		save_req = 1'b0;
		wait_transfer();
		check_value("save sectors", sector_count(ram_mask_file, rtc_inuse), sectors);

		// Autosave once the OSD opens
		start_counts(1'b0);
		cram_wr = 1'b1;
		next_cycle();
		cram_wr = 1'b0;
		next_cycle();
		check_value("sav_pending set", 1, sav_pending);
		autosave_en = 1'b1;
		osd_status  = 1'b1;
		while (!bk_busy)
			@(negedge clk_sys);
		@(negedge clk_sys);
		check_value("sav_pending cleared", 0, sav_pending);
		wait_transfer();
		check_value("autosave sectors", sector_count(ram_mask_file, rtc_inuse), sectors);

		if (valid_count == 1 && !sav_pending) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Unexpected state at the end of the run");
			$display("Verification failed");
			$fatal(1);
		end
	end

endmodule

/* verif/tb_sd_host_model.sv */
// SD host model
// Answers sector requests with an acknowledge and streams buffer words on loads

module tb_sd_host_model #(
	parameter int WORDS = 8
) (
	input  logic        clk_sys,
	input  logic        sd_rd,
	input  logic        sd_wr,
	input  logic [7:0]  sd_lba,
	output logic        sd_ack,
	output logic [7:0]  sd_buff_addr,
	output logic        sd_buff_wr,
	output logic [15:0] sd_buff_dout
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
	end

	// One sector, data pushed only when the request was a read
	task automatic serve_sector(input logic is_read);
		@(posedge clk_sys);
		#2;
		sd_ack = 1'b1;
		for (int i = 0; i < WORDS; i++) begin
			@(posedge clk_sys);
			#2;
			sd_buff_addr = i[7:0];
			sd_buff_wr   = is_read;
			sd_buff_dout = {sd_lba, i[7:0]} ^ 16'hC3A5;
			@(posedge clk_sys);
			#2;
			sd_buff_wr = 1'b0;
		end
		@(posedge clk_sys);
		#2;
		sd_ack = 1'b0;
	endtask

	// Look at the request once the edge has settled
	always begin
		@(posedge clk_sys);
		#1;
		if ((sd_rd || sd_wr) && !sd_ack)
			serve_sector(sd_rd);
	end

endmodule

/* verilog/backup_sector_sequencer.sv */
// Backup RAM sector sequencer
// Loads and saves cartridge RAM through the SD host one sector at a time,
// with an optional trailing sector that holds the real-time clock

module backup_sector_sequencer #(
	parameter int LBA_W = 32
) (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic                                    cart_download,
	input  logic                                    cart_end,
	input  logic                                    img_mounted,
	input  logic                                    img_readonly,
	input  logic                                    img_size_nonzero,
	input  logic                                    cart_has_save,
	input  logic                                    cram_wr,
	input  logic                                    osd_status,
	input  logic                                    load_req,
	input  logic                                    save_req,
	input  logic                                    autosave_en,
	input  logic [7:0]                              ram_mask_file,
	input  logic                                    rtc_inuse,
	input  logic [31:0]                             rtc_timestamp,
	input  logic [47:0]                             rtc_savedtime,
	input  logic                                    sd_ack,
	input  logic [gb_support_pkg::sector_addr_w-1:0] sd_buff_addr,
	input  logic                                    sd_buff_wr,
	input  logic [gb_support_pkg::io_data_w-1:0]     sd_buff_dout,
	input  logic [gb_support_pkg::io_data_w-1:0]     bk_q,
	output logic [LBA_W-1:0]                        sd_lba,
	output logic                                    sd_rd,
	output logic                                    sd_wr,
	output logic [gb_support_pkg::io_data_w-1:0]     sd_buff_din,
	output logic [gb_support_pkg::sector_addr_w+7:0] bk_addr,
	output logic [gb_support_pkg::io_data_w-1:0]     bk_data,
	output logic                                    bk_wr,
	output logic                                    bk_rtc_wr,
	output logic                                    bk_busy,
	output logic                                    bk_loading,
	output logic                                    sav_pending,
	output logic                                    sav_supported
);

	localparam int rtc_idx_w = $clog2(gb_support_pkg::rtc_words);

	logic       bk_ena;
	logic       new_load;
	logic       cart_q;
	logic       bk_state;
	logic       load_q;
	logic       save_q;
	logic       ack_q;
	logic       bk_load;
	logic       bk_save;
	logic       start_user;
	logic       start_auto;
	logic       start_rd;
	logic       last_sector;
	logic       rtc_sector;
	logic [7:0] lba_low;
	logic [gb_support_pkg::rtc_words-1:0][gb_support_pkg::io_data_w-1:0] rtc_word;

	assign sav_supported = cart_has_save & bk_ena;
	assign bk_busy       = bk_state;

	////////////////////
	// Enable and pending
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_q      <= 1'b0;
			bk_ena      <= 1'b0;
			new_load    <= 1'b0;
			sav_pending <= 1'b0;
		end else begin
			cart_q <= cart_download;
			// A new cartridge drops the old save file until its image is mounted
			if (cart_download & ~cart_q)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (cart_end & sav_supported)
				new_load <= 1'b1;
			else if (bk_state)
				new_load <= 1'b0;

			if (cram_wr & ~osd_status & sav_supported)
				sav_pending <= 1'b1;
			else if (bk_state)
				sav_pending <= 1'b0;
		end
	end

	////////////////////
	// Sector loop
	////////////////////
	assign bk_load    = load_req | new_load;
	assign bk_save    = save_req | (sav_pending & osd_status & autosave_en);
	assign start_user = bk_ena & ((bk_load & ~load_q) | (bk_save & ~save_q));
	assign start_auto = cart_end & img_size_nonzero & bk_ena;
	assign start_rd   = bk_load | start_auto;

	assign lba_low    = sd_lba[7:0];
	assign rtc_sector = lba_low > ram_mask_file;
	// The clock adds one sector past the RAM image
	assign last_sector = rtc_inuse ? rtc_sector : (lba_low >= ram_mask_file);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
			bk_state   <= 1'b0;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			load_q <= bk_load;
			save_q <= bk_save;
			ack_q  <= sd_ack;

			// Host has taken the request
			if (sd_ack & ~ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_state) begin
				if (start_user | start_auto) begin
					bk_state   <= 1'b1;
					bk_loading <= start_rd;
					sd_lba     <= '0;
					sd_rd      <= start_rd;
					sd_wr      <= ~start_rd;
				end
			end else if (ack_q & ~sd_ack) begin
				if (last_sector) begin
					bk_state   <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + {{(LBA_W-1){1'b0}}, 1'b1};
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	////////////////////
	// Buffer routing
	////////////////////
	assign bk_addr   = {lba_low, sd_buff_addr};
	assign bk_data   = sd_buff_dout;
	assign bk_wr     = ~rtc_sector & sd_buff_wr & sd_ack;
	assign bk_rtc_wr = rtc_sector & sd_buff_wr & sd_ack;

	// Clock sector layout, timestamp low word first, then saved time
	assign rtc_word = {rtc_savedtime, rtc_timestamp};

	always_comb begin
		if (!rtc_sector)
			sd_buff_din = bk_q;
		else if (sd_buff_addr < gb_support_pkg::rtc_words)
			sd_buff_din = rtc_word[sd_buff_addr[rtc_idx_w-1:0]];
		else
			sd_buff_din = '1;
	end

endmodule

/* verilog/boot_rom_monitor.sv */
// Boot ROM monitor
// Remembers custom boot ROM loads and checksums the colour boot ROM
// to decide whether fast boot and GBA mode are offered

module boot_rom_monitor (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                ioctl_wr,
	input  logic [gb_support_pkg::io_data_w-1:0] ioctl_dout,
	input  logic                                cgb_boot_download,
	input  logic                                dmg_boot_download,
	input  logic                                boot_start,
	input  logic                                is_gbc,
	output logic                                fastboot_available,
	output logic                                boot_gba_available,
	output logic                                real_cgb_boot
);

	localparam int cw = gb_support_pkg::checksum_w;

	logic          custom_dmg;
	logic          custom_cgb;
	logic [cw-1:0] checksum;
	logic [cw-1:0] byte_hi;
	logic [cw-1:0] byte_lo;
	logic          custom_match;

	assign byte_hi = {{(cw-8){1'b0}}, ioctl_dout[15:8]};
	assign byte_lo = {{(cw-8){1'b0}}, ioctl_dout[7:0]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			custom_dmg <= 1'b0;
			custom_cgb <= 1'b0;
			checksum   <= '0;
		end else begin
			// Once loaded, a custom image stays in place until reset
			if (cgb_boot_download)
				custom_cgb <= 1'b1;
			if (dmg_boot_download)
				custom_dmg <= 1'b1;

			if (boot_start)
				checksum <= '0;
			else if (cgb_boot_download && ioctl_wr)
				checksum <= checksum + byte_hi + byte_lo;
		end
	end

	assign custom_match  = (checksum == gb_support_pkg::cgb_custom_checksum);
	assign real_cgb_boot = (checksum == gb_support_pkg::cgb_original_checksum);

	// Fast boot needs the built-in ROM or the known custom colour ROM
	assign fastboot_available = !((is_gbc && custom_cgb && !custom_match) ||
		(!is_gbc && custom_dmg));

	// GBA mode works with the built-in, the original or the known custom ROM
	assign boot_gba_available = !custom_cgb || real_cgb_boot || custom_match;

endmodule

/* verilog/cheat_code_loader.sv */
// Cheat code loader
// Collects eight host words into one cheat code and flags it complete

module cheat_code_loader (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                cheat_download,
	input  logic                                ioctl_wr,
	input  logic [gb_support_pkg::io_addr_w-1:0] ioctl_addr,
	input  logic [gb_support_pkg::io_data_w-1:0] ioctl_dout,
	output gb_support_pkg::cheat_code_t         cheat_code,
	output logic                                code_valid
);

	logic       word_wr;
	logic [2:0] slot;

	// Only even byte offsets carry a word
	assign word_wr = cheat_download & ioctl_wr & ~ioctl_addr[0];

	// Offset pairs go flags, address, compare, replace from the top field down.
	// Within a pair the low word comes first
	assign slot = {~ioctl_addr[3], ~ioctl_addr[2], ioctl_addr[1]};

	always_ff @(posedge clk_sys) begin
		if (word_wr)
			cheat_code.words[slot] <= ioctl_dout;
	end

	// Replace high word at offset 14 closes the code
	always_ff @(posedge clk_sys) begin
		if (reset)
			code_valid <= 1'b0;
		else
			code_valid <= word_wr && (ioctl_addr[3:0] == 4'd14);
	end

endmodule

/* verilog/download_router.sv */
// Download router
// Sorts the host download by file type and marks colour boot start and cartridge end

module download_router (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ioctl_download,
	input  logic [7:0] filetype,
	output logic       cart_download,
	output logic       palette_download,
	output logic       border_download,
	output logic       cgb_boot_download,
	output logic       dmg_boot_download,
	output logic       sgb_boot_download,
	output logic       boot_download,
	output logic       cheat_download,
	output logic       boot_start,
	output logic       cart_end
);

	logic cart_q;
	logic cgb_boot_q;

	// Cartridge covers every system variant of the low code, MegaDuck included
	assign cart_download = ioctl_download &&
		(filetype[5:0] == gb_support_pkg::ft_cart_low || filetype == gb_support_pkg::ft_cart_alt);

	assign palette_download  = ioctl_download && (filetype == gb_support_pkg::ft_palette);
	assign border_download   = ioctl_download && (filetype == gb_support_pkg::ft_sgb_border);
	assign cgb_boot_download = ioctl_download && (filetype == gb_support_pkg::ft_cgb_boot);
	assign dmg_boot_download = ioctl_download && (filetype == gb_support_pkg::ft_dmg_boot);
	assign sgb_boot_download = ioctl_download && (filetype == gb_support_pkg::ft_sgb_boot);
	assign cheat_download    = ioctl_download && (filetype == gb_support_pkg::ft_cheat);
	assign boot_download     = cgb_boot_download | dmg_boot_download | sgb_boot_download;

	// Edge pulses land one cycle after the class changes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_q     <= 1'b0;
			cgb_boot_q <= 1'b0;
			boot_start <= 1'b0;
			cart_end   <= 1'b0;
		end else begin
			cart_q     <= cart_download;
			cgb_boot_q <= cgb_boot_download;
			boot_start <= cgb_boot_download & ~cgb_boot_q;
			cart_end   <= cart_q & ~cart_download;
		end
	end

endmodule

/* verilog/gb_support_pkg.sv */
// Shared definitions for the console support logic
// Bus widths, boot ROM checksums, download file-type codes and the cheat code layout

package gb_support_pkg;

	// Host download stream
	localparam int io_addr_w = 25;
	localparam int io_data_w = 16;

	// Colour boot ROM identification
	localparam int checksum_w = 18;
	localparam logic [checksum_w-1:0] cgb_custom_checksum   = 18'h2CE10;
	localparam logic [checksum_w-1:0] cgb_original_checksum = 18'h2F3EA;

	////////////////////
	// File-type codes
	////////////////////
	localparam logic [7:0] ft_sgb_border = 8'h02;
	localparam logic [7:0] ft_palette    = 8'h03;
	localparam logic [7:0] ft_cgb_boot   = 8'h04;
	localparam logic [7:0] ft_dmg_boot   = 8'h05;
	localparam logic [7:0] ft_sgb_boot   = 8'h06;
	localparam logic [7:0] ft_megaduck   = 8'h81;
	localparam logic [7:0] ft_cheat      = 8'hFF;
	// Cartridge images match on the low six bits, system select sits above
	localparam logic [5:0] ft_cart_low   = 6'h01;
	localparam logic [7:0] ft_cart_alt   = 8'h80;

	// Backup RAM sectors
	localparam int sector_addr_w = 8;
	localparam int rtc_words     = 5;

	////////////////////
	// Cheat code
	////////////////////
	// Word view is written by the loader, field view is read by the core.
	// Each 32-bit field arrives low word first
	typedef union packed {
		logic [7:0][io_data_w-1:0] words;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
	} cheat_code_t;

endpackage

/* verilog/gb_support_top.sv */
// Console support logic top level
// Download classification, boot ROM tracking, cheat loading and backup RAM transfers

module gb_support_top #(
	parameter int LBA_W = 32
) (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	// Host download stream
	input  logic                                    ioctl_download,
	input  logic                                    ioctl_wr,
	input  logic [gb_support_pkg::io_addr_w-1:0]     ioctl_addr,
	input  logic [gb_support_pkg::io_data_w-1:0]     ioctl_dout,
	input  logic [7:0]                              filetype,
	input  logic                                    is_gbc,
	// SD image and sector buffer
	input  logic                                    img_mounted,
	input  logic                                    img_readonly,
	input  logic                                    img_size_nonzero,
	input  logic                                    sd_ack,
	input  logic [gb_support_pkg::sector_addr_w-1:0] sd_buff_addr,
	input  logic                                    sd_buff_wr,
	input  logic [gb_support_pkg::io_data_w-1:0]     sd_buff_dout,
	// Cartridge and clock state
	input  logic [gb_support_pkg::io_data_w-1:0]     bk_q,
	input  logic                                    cart_has_save,
	input  logic [7:0]                              ram_mask_file,
	input  logic                                    rtc_inuse,
	input  logic [31:0]                             rtc_timestamp,
	input  logic [47:0]                             rtc_savedtime,
	input  logic                                    cram_wr,
	// OSD controls
	input  logic                                    osd_status,
	input  logic                                    load_req,
	input  logic                                    save_req,
	input  logic                                    autosave_en,

	output logic                                    cart_download,
	output logic                                    palette_download,
	output logic                                    border_download,
	output logic                                    boot_download,
	output logic                                    fastboot_available,
	output logic                                    boot_gba_available,
	output logic                                    real_cgb_boot,
	output gb_support_pkg::cheat_code_t             cheat_code,
	output logic                                    code_valid,
	output logic [LBA_W-1:0]                        sd_lba,
	output logic                                    sd_rd,
	output logic                                    sd_wr,
	output logic [gb_support_pkg::io_data_w-1:0]     sd_buff_din,
	output logic [gb_support_pkg::sector_addr_w+7:0] bk_addr,
	output logic [gb_support_pkg::io_data_w-1:0]     bk_data,
	output logic                                    bk_wr,
	output logic                                    bk_rtc_wr,
	output logic                                    bk_busy,
	output logic                                    bk_loading,
	output logic                                    sav_pending,
	output logic                                    sav_supported
);

	logic cgb_boot_download;
	logic dmg_boot_download;
	logic cheat_download;
	logic boot_start;
	logic cart_end;

	download_router u_download_router (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.ioctl_download    (ioctl_download),
		.filetype          (filetype),
		.cart_download     (cart_download),
		.palette_download  (palette_download),
		.border_download   (border_download),
		.cgb_boot_download (cgb_boot_download),
		.dmg_boot_download (dmg_boot_download),
		// SGB boot ROM image is taken by the console core itself
		.sgb_boot_download (),
		.boot_download     (boot_download),
		.cheat_download    (cheat_download),
		.boot_start        (boot_start),
		.cart_end          (cart_end)
	);

	boot_rom_monitor u_boot_rom_monitor (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.ioctl_wr           (ioctl_wr),
		.ioctl_dout         (ioctl_dout),
		.cgb_boot_download  (cgb_boot_download),
		.dmg_boot_download  (dmg_boot_download),
		.boot_start         (boot_start),
		.is_gbc             (is_gbc),
		.fastboot_available (fastboot_available),
		.boot_gba_available (boot_gba_available),
		.real_cgb_boot      (real_cgb_boot)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cheat_download (cheat_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.cheat_code     (cheat_code),
		.code_valid     (code_valid)
	);

	backup_sector_sequencer #(
		.LBA_W (LBA_W)
	) u_backup_sector_sequencer (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.cart_download    (cart_download),
		.cart_end         (cart_end),
		.img_mounted      (img_mounted),
		.img_readonly     (img_readonly),
		.img_size_nonzero (img_size_nonzero),
		.cart_has_save    (cart_has_save),
		.cram_wr          (cram_wr),
		.osd_status       (osd_status),
		.load_req         (load_req),
		.save_req         (save_req),
		.autosave_en      (autosave_en),
		.ram_mask_file    (ram_mask_file),
		.rtc_inuse        (rtc_inuse),
		.rtc_timestamp    (rtc_timestamp),
		.rtc_savedtime    (rtc_savedtime),
		.sd_ack           (sd_ack),
		.sd_buff_addr     (sd_buff_addr),
		.sd_buff_wr       (sd_buff_wr),
		.sd_buff_dout     (sd_buff_dout),
		.bk_q             (bk_q),
		.sd_lba           (sd_lba),
		.sd_rd            (sd_rd),
		.sd_wr            (sd_wr),
		.sd_buff_din      (sd_buff_din),
		.bk_addr          (bk_addr),
		.bk_data          (bk_data),
		.bk_wr            (bk_wr),
		.bk_rtc_wr        (bk_rtc_wr),
		.bk_busy          (bk_busy),
		.bk_loading       (bk_loading),
		.sav_pending      (sav_pending),
		.sav_supported    (sav_supported)
	);

endmodule
